// ==== design/noc_pkg.sv ====
package noc_pkg;

   // widths
   localparam int FLIT_DATA_W = 32;
   localparam int EPOCH_W     = 10;
   localparam int COUNT_W     = 10;
   localparam int PROB_W      = 12;
   localparam int PRIV_W      = 4;
   localparam int DROP_W      = 16;
   localparam int AXIL_ADDR_W = 8;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   // configuration after reset
   localparam logic [EPOCH_W-1:0] EPOCH_LEN_RST = 10'd1000;
   localparam logic [COUNT_W-1:0] THRESHOLD_RST = 10'd700;
   localparam logic [PROB_W-1:0]  PROBATION_RST = 12'd2002;

   // lowest privilege level allowed to write
   localparam logic [PRIV_W-1:0] PRIV_WRITE_MIN = 4'd2;

   // register map
   localparam logic [AXIL_ADDR_W-1:0] ADDR_EPOCH      = 8'h00;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_THRESHOLD  = 8'h04;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_PROBATION  = 8'h08;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS     = 8'h0C;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_DROPS      = 8'h10;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_LAST_COUNT = 8'h14;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef struct packed {
      logic                   valid;
      logic                   head;
      logic                   tail;
      logic [FLIT_DATA_W-1:0] data;
   } flit_t;

   typedef struct packed {
      logic               detected;
      logic               blocked;
      logic [PROB_W-1:0]  countdown;
      logic [COUNT_W-1:0] last_count;
   } guard_status_t;

   typedef struct packed {
      logic [EPOCH_W-1:0] epoch_len;
      logic [COUNT_W-1:0] threshold;
      logic [PROB_W-1:0]  probation;
   } guard_cfg_t;

   localparam guard_cfg_t CFG_RST = '{epoch_len: EPOCH_LEN_RST,
                                      threshold: THRESHOLD_RST,
                                      probation: PROBATION_RST};

endpackage

// ==== design/dos_monitor.sv ====
`timescale 1ns/1ps

module dos_monitor
   import noc_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  guard_cfg_t    cfg,
   input  logic          head_seen,
   input  logic          clear_block,
   output guard_status_t status
);

   logic [EPOCH_W-1:0] epoch;
   logic [COUNT_W-1:0] pkt_count;
   logic [COUNT_W-1:0] last_count;
   logic [PROB_W-1:0]  countdown;
   logic               detected;
   logic               blocked;
   logic               wrap;
   logic               over;
   logic               probe_done;

   // >= so a shortened epoch takes effect at once
   assign wrap       = (epoch >= cfg.epoch_len);
   assign over       = (pkt_count >= cfg.threshold);
   assign probe_done = wrap && detected && (countdown == '0);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         epoch <= '0;
      end else if (wrap) begin
         epoch <= '0;
      end else begin
         epoch <= epoch + 1'b1;
      end
   end

   // a head arriving on the wrap cycle counts toward the new epoch
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pkt_count  <= '0;
         last_count <= '0;
      end else if (wrap) begin
         last_count <= pkt_count;
         pkt_count  <= COUNT_W'(head_seen);
      end else if (head_seen && pkt_count != '1) begin
         pkt_count <= pkt_count + 1'b1;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         detected <= 1'b0;
         blocked  <= 1'b0;
      end else if (clear_block) begin
         detected <= 1'b0;
         blocked  <= 1'b0;
      end else begin
         if (wrap && over) begin
            detected <= 1'b1;
         end else if (probe_done) begin
            detected <= 1'b0;
         end
         // still flooding after probation
         if (probe_done && over) begin
            blocked <= 1'b1;
         end
      end
   end

   // idle countdown follows the programmed probation
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         countdown <= PROBATION_RST;
      end else if (clear_block || !detected) begin
         countdown <= cfg.probation;
      end else if (countdown != '0) begin
         countdown <= countdown - 1'b1;
      end else if (probe_done && !over) begin
         countdown <= cfg.probation;
      end
   end

   assign status = '{detected: detected, blocked: blocked,
                     countdown: countdown, last_count: last_count};

   // block only follows an earlier detection
   assert property (@(posedge clk) disable iff (reset)
      $rose(blocked) |-> $past(detected));

   // once expired the countdown holds at zero or reloads
   assert property (@(posedge clk) disable iff (reset)
      countdown == '0 |=> (countdown == '0 || countdown == $past(cfg.probation)));

endmodule

// ==== design/inject_gate.sv ====
`timescale 1ns/1ps

module inject_gate
   import noc_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  flit_t             in_flit,
   output logic              in_ready,
   output flit_t             out_flit,
   input  logic              out_ready,
   input  guard_status_t     status,
   output logic              head_seen,
   output logic [DROP_W-1:0] drop_count
);

   logic                   out_valid;
   logic                   out_head;
   logic                   out_tail;
   logic [FLIT_DATA_W-1:0] out_data;
   logic                   in_pkt;
   logic                   drop_pkt;
   logic                   phase;
   logic                   drop_flit;
   logic                   pass_ready;
   logic                   throttle;
   logic                   accept;

   // outside a packet the next flit is a head, so the block decides
   assign drop_flit  = in_pkt ? drop_pkt : status.blocked;
   assign pass_ready = !out_valid || out_ready;
   assign throttle   = status.detected && phase;
   assign in_ready   = drop_flit || (pass_ready && !throttle);
   assign accept     = in_flit.valid && in_ready;
   assign head_seen  = accept && in_flit.head;

   // half rate while detected
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         phase <= 1'b0;
      end else begin
         phase <= status.detected ? !phase : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_pkt   <= 1'b0;
         drop_pkt <= 1'b0;
      end else if (accept) begin
         if (!in_pkt) begin
            drop_pkt <= status.blocked;
         end
         in_pkt <= !in_flit.tail;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (pass_ready) begin
         out_valid <= accept && !drop_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (pass_ready && accept && !drop_flit) begin
         out_head <= in_flit.head;
         out_tail <= in_flit.tail;
         out_data <= in_flit.data;
      end
   end

   assign out_flit = '{valid: out_valid, head: out_head, tail: out_tail, data: out_data};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         drop_count <= '0;
      end else if (accept && drop_flit && drop_count != '1) begin
         drop_count <= drop_count + 1'b1;
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      (out_flit.valid && !out_ready) |=> $stable(out_flit));

endmodule

// ==== design/guard_csr.sv ====
`timescale 1ns/1ps

module guard_csr
   import noc_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   priv_inc,
   input  logic                   priv_dec,
   input  guard_status_t          status,
   input  logic [DROP_W-1:0]      drop_count,
   input  logic [AXIL_ADDR_W-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [AXIL_DATA_W-1:0] wdata,
   input  logic [AXIL_STRB_W-1:0] wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [AXIL_ADDR_W-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [AXIL_DATA_W-1:0] rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready,
   output guard_cfg_t             cfg,
   output logic                   clear_block
);

   logic [PRIV_W-1:0]      priv;
   logic                   aw_held;
   logic                   w_held;
   logic [AXIL_ADDR_W-1:0] aw_addr_q;
   logic [AXIL_DATA_W-1:0] w_data_q;
   logic [AXIL_STRB_W-1:0] w_strb_q;
   logic [AXIL_ADDR_W-1:0] wr_addr;
   logic [AXIL_DATA_W-1:0] wr_data;
   logic [AXIL_STRB_W-1:0] wr_strb;
   logic [AXIL_DATA_W-1:0] wr_mask;
   logic [AXIL_DATA_W-1:0] wr_cur;
   logic [AXIL_DATA_W-1:0] wr_merged;
   logic                   wr_mapped;
   logic                   wr_ok;
   logic                   have_aw;
   logic                   have_w;
   logic                   do_write;
   logic [AXIL_DATA_W-1:0] rd_data;
   logic                   rd_mapped;

   // saturating privilege level
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         priv <= '0;
      end else if (priv_inc && !priv_dec && priv != '1) begin
         priv <= priv + 1'b1;
      end else if (priv_dec && !priv_inc && priv != '0) begin
         priv <= priv - 1'b1;
      end
   end

   // aw and w may arrive in either order
   assign awready  = !aw_held && !bvalid;
   assign wready   = !w_held && !bvalid;
   assign have_aw  = aw_held || (awvalid && awready);
   assign have_w   = w_held || (wvalid && wready);
   assign do_write = have_aw && have_w && !bvalid;

   assign wr_addr = aw_held ? aw_addr_q : awaddr;
   assign wr_data = w_held ? w_data_q : wdata;
   assign wr_strb = w_held ? w_strb_q : wstrb;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else if (do_write) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end else begin
         if (awvalid && awready) begin
            aw_held <= 1'b1;
         end
         if (wvalid && wready) begin
            w_held <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         aw_addr_q <= awaddr;
      end
      if (wvalid && wready) begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
   end

   always_comb begin
      for (int i = 0; i < AXIL_STRB_W; i++) begin
         wr_mask[8*i +: 8] = {8{wr_strb[i]}};
      end
      wr_mapped = 1'b1;
      case (wr_addr)
         ADDR_EPOCH:     wr_cur = AXIL_DATA_W'(cfg.epoch_len);
         ADDR_THRESHOLD: wr_cur = AXIL_DATA_W'(cfg.threshold);
         ADDR_PROBATION: wr_cur = AXIL_DATA_W'(cfg.probation);
         ADDR_STATUS:    wr_cur = '0;
         default: begin
            wr_cur    = '0;
            wr_mapped = 1'b0;
         end
      endcase
   end

   assign wr_merged   = (wr_cur & ~wr_mask) | (wr_data & wr_mask);
   assign wr_ok       = wr_mapped && (priv >= PRIV_WRITE_MIN);
   assign clear_block = do_write && wr_ok && (wr_addr == ADDR_STATUS) && wr_merged[1];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg <= CFG_RST;
      end else if (do_write && wr_ok) begin
         case (wr_addr)
            ADDR_EPOCH:     cfg.epoch_len <= wr_merged[EPOCH_W-1:0];
            ADDR_THRESHOLD: cfg.threshold <= wr_merged[COUNT_W-1:0];
            ADDR_PROBATION: cfg.probation <= wr_merged[PROB_W-1:0];
            default:        cfg <= cfg;
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         bvalid <= 1'b0;
      end else if (do_write) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // read decode
   always_comb begin
      rd_data   = '0;
      rd_mapped = 1'b1;
      case (araddr)
         ADDR_EPOCH:      rd_data = AXIL_DATA_W'(cfg.epoch_len);
         ADDR_THRESHOLD:  rd_data = AXIL_DATA_W'(cfg.threshold);
         ADDR_PROBATION:  rd_data = AXIL_DATA_W'(cfg.probation);
         ADDR_STATUS: begin
            rd_data[0]     = status.detected;
            rd_data[1]     = status.blocked;
            rd_data[7:4]   = priv;
            rd_data[27:16] = status.countdown;
         end
         ADDR_DROPS:      rd_data = AXIL_DATA_W'(drop_count);
         ADDR_LAST_COUNT: rd_data = AXIL_DATA_W'(status.last_count);
         default:         rd_mapped = 1'b0;
      endcase
   end

   assign arready = !rvalid;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else if (arvalid && arready) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         rdata <= rd_data;
         rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
      end
   end

   assert property (@(posedge clk) disable iff (reset) (bvalid && !bready) |=> bvalid);
   assert property (@(posedge clk) disable iff (reset) (rvalid && !rready) |=> rvalid);

endmodule

// ==== design/router_guard.sv ====
`timescale 1ns/1ps

module router_guard
   import noc_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // node injection channel
   input  flit_t                  in_flit,
   output logic                   in_ready,
   // toward the router
   output flit_t                  out_flit,
   input  logic                   out_ready,
   input  logic                   priv_inc,
   input  logic                   priv_dec,
   output logic                   dos_detected,
   output logic                   port_blocked,
   // axi-lite config port
   input  logic [AXIL_ADDR_W-1:0] awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [AXIL_DATA_W-1:0] wdata,
   input  logic [AXIL_STRB_W-1:0] wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [AXIL_ADDR_W-1:0] araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [AXIL_DATA_W-1:0] rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready
);

   guard_cfg_t        cfg;
   guard_status_t     status;
   logic              clear_block;
   logic              head_seen;
   logic [DROP_W-1:0] drop_count;

   assign dos_detected = status.detected;
   assign port_blocked = status.blocked;

   dos_monitor u_monitor (.clk, .reset, .cfg, .head_seen, .clear_block, .status);

   inject_gate u_gate (.clk, .reset, .in_flit, .in_ready, .out_flit, .out_ready,
                       .status, .head_seen, .drop_count);

   guard_csr u_csr (.clk, .reset, .priv_inc, .priv_dec, .status, .drop_count,
                    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
                    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
                    .rdata, .rresp, .rvalid, .rready, .cfg, .clear_block);

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic reset
);

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
   end
   return v;
endfunction

task automatic check_flit(input string name, input flit_t got, input flit_t exp);
   if (got !== exp) begin
      value_errors++;
      $display("Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
   end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      value_errors++;
      $display("Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
   end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
   if (got !== exp) begin
      value_errors++;
      $display("Error at %0d ns: %s expected %b got %b", $time, name, exp, got);
   end
endtask

function automatic logic signal_level(input string name);
   if (name == "write_ready") begin
      return awready && wready;
   end else if (name == "arready") begin
      return arready;
   end else if (name == "bvalid") begin
      return bvalid;
   end else if (name == "rvalid") begin
      return rvalid;
   end else if (name == "dos_detected") begin
      return dos_detected;
   end
   return port_blocked;
endfunction

// returns mid cycle once the signal is at level
task automatic wait_level(input string name, input logic level, input int limit);
   int n;
   n = 0;
   @(negedge clk);
   while (signal_level(name) !== level && n < limit) begin
      @(negedge clk);
      n++;
   end
   if (signal_level(name) !== level) begin
      other_errors++;
      $display("%s did not reach %b within %0d cycles at %0d ns", name, level, limit, $time);
   end
endtask

task automatic wait_cycles(input int n);
   repeat (n) @(posedge clk);
   #1;
endtask

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
   awaddr  = addr;
   wdata   = data;
   wstrb   = 4'hf;
   awvalid = 1'b1;
   wvalid  = 1'b1;
   wait_level("write_ready", 1'b1, TIMEOUT);
   @(posedge clk);
   #1;
   awvalid = 1'b0;
   wvalid  = 1'b0;
   bready  = 1'b1;
   wait_level("bvalid", 1'b1, TIMEOUT);
   resp = bresp;
   @(posedge clk);
   #1;
   bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
   araddr  = addr;
   arvalid = 1'b1;
   wait_level("arready", 1'b1, TIMEOUT);
   @(posedge clk);
   #1;
   arvalid = 1'b0;
   rready  = 1'b1;
   wait_level("rvalid", 1'b1, TIMEOUT);
   data = rdata;
   resp = rresp;
   @(posedge clk);
   #1;
   rready = 1'b0;
endtask

task automatic priv_pulse(input logic inc, input logic dec);
   priv_inc = inc;
   priv_dec = dec;
   @(posedge clk);
   #1;
   priv_inc = 1'b0;
   priv_dec = 1'b0;
endtask

// holds the flit until in_ready is seen mid cycle
task automatic send_flit(input flit_t f, input bit stall);
   int          n;
   logic        taken;
   logic [31:0] rb;
   n = 0;
   taken = 1'b0;
   in_flit = f;
   while (!taken && n < TIMEOUT) begin
      rb = rand_bits(1);
      out_ready = stall ? rb[0] : 1'b1;
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #1;
      n++;
   end
   in_flit = '0;
   out_ready = 1'b1;
   if (!taken) begin
      other_errors++;
      $display("flit %h was not accepted within %0d cycles", f, TIMEOUT);
   end
endtask

task automatic send_packet(input int len, input bit stall);
   flit_t f;
   for (int i = 0; i < len; i++) begin
      f = '{valid: 1'b1, head: (i == 0), tail: (i == len - 1), data: rand_bits(32)};
      sent_q.push_back(f);
      send_flit(f, stall);
   end
endtask

task automatic flood_heads(input string name, input int limit);
   int n;
   n = 0;
   while (signal_level(name) !== 1'b1 && n < limit) begin
      send_packet(1, 1'b0);
      n++;
   end
   if (signal_level(name) !== 1'b1) begin
      other_errors++;
      $display("%s stayed low after %0d flooding packets", name, limit);
   end
endtask

task automatic start_window();
   sent_q.delete();
   got_mark = got_q.size();
endtask

task automatic drain_and_compare();
   int n;
   n = 0;
   out_ready = 1'b1;
   while (got_q.size() - got_mark < sent_q.size() && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
   end
   check_word("flits received", got_q.size() - got_mark, sent_q.size());
   for (int i = 0; i < sent_q.size() && got_mark + i < got_q.size(); i++) begin
      check_flit($sformatf("out_flit[%0d]", i), got_q[got_mark + i], sent_q[i]);
   end
endtask

task automatic test_reset_values();
   logic [31:0] d;
   logic [1:0]  r;
   // in_ready, out valid, detected, blocked, awready, wready, arready, bvalid, rvalid
   check_word("outputs after reset",
              32'({in_ready, out_flit.valid, dos_detected, port_blocked,
                   awready, wready, arready, bvalid, rvalid}), 32'h11C);
   axi_read(ADDR_EPOCH, d, r);
   check_word("epoch_len", d, 32'd1000);
   axi_read(ADDR_PROBATION, d, r);
   check_word("probation", d, 32'd2002);
endtask

task automatic test_privilege();
   logic [31:0] d;
   logic [1:0]  r;
   axi_write(ADDR_THRESHOLD, 32'd123, r);
   check_resp("bresp", r, RESP_SLVERR);
   axi_read(ADDR_THRESHOLD, d, r);
   check_word("threshold", d, 32'd700);
   repeat (2) priv_pulse(1'b1, 1'b0);
   axi_write(ADDR_THRESHOLD, 32'd123, r);
   check_resp("bresp", r, RESP_OKAY);
   axi_read(ADDR_THRESHOLD, d, r);
   check_resp("rresp", r, RESP_OKAY);
   check_word("threshold", d, 32'd123);
   repeat (17) priv_pulse(1'b1, 1'b0);
   axi_read(ADDR_STATUS, d, r);
   check_word("priv level", 32'(d[7:4]), 32'd15);
   priv_pulse(1'b0, 1'b1);
   axi_read(ADDR_STATUS, d, r);
   check_word("priv level", 32'(d[7:4]), 32'd14);
   // level 14 leaves room to move either way
   priv_pulse(1'b1, 1'b1);
   axi_read(ADDR_STATUS, d, r);
   check_word("priv level", 32'(d[7:4]), 32'd14);
   axi_read(8'h40, d, r);
   check_resp("rresp", r, RESP_SLVERR);
endtask

task automatic test_pass_through();
   logic [31:0] d;
   logic [1:0]  r;
   int          n;
   axi_write(ADDR_EPOCH, 32'd300, r);
   check_resp("bresp", r, RESP_OKAY);
   // a lone head marks the next epoch boundary
   send_packet(1, 1'b0);
   n = 0;
   d = '0;
   while (d == 0 && n < 200) begin
      axi_read(ADDR_LAST_COUNT, d, r);
      n++;
   end
   check_word("last_count", d, 32'd1);
   start_window();
   for (int p = 0; p < 8; p++) begin
      send_packet(1 + rand_bits(2), 1'b1);
   end
   drain_and_compare();
   n = 0;
   while (d == 1 && n < 200) begin
      axi_read(ADDR_LAST_COUNT, d, r);
      n++;
   end
   check_word("last_count", d, 32'd8);
endtask

task automatic test_detection();
   logic [31:0] d;
   logic [1:0]  r;
   axi_write(ADDR_EPOCH, 32'd30, r);
   check_resp("bresp", r, RESP_OKAY);
   axi_write(ADDR_THRESHOLD, 32'd5, r);
   check_resp("bresp", r, RESP_OKAY);
   axi_write(ADDR_PROBATION, 32'd40, r);
   check_resp("bresp", r, RESP_OKAY);
   flood_heads("dos_detected", 200);
   axi_read(ADDR_STATUS, d, r);
   check_word("status detected", 32'(d[0]), 32'd1);
   // short burst at half rate and then quiet
   for (int i = 0; i < 8; i++) begin
      send_packet(1, 1'b0);
   end
endtask

task automatic test_recovery();
   logic [31:0] d;
   logic [1:0]  r;
   wait_level("dos_detected", 1'b0, TIMEOUT);
   @(posedge clk);
   #1;
   axi_read(ADDR_STATUS, d, r);
   check_word("status detected", 32'(d[0]), 32'd0);
   check_word("status countdown", 32'(d[27:16]), 32'd40);
endtask

task automatic test_block();
   logic [31:0] d0;
   logic [31:0] d;
   logic [1:0]  r;
   flood_heads("port_blocked", 1000);
   wait_cycles(4);
   start_window();
   axi_read(ADDR_DROPS, d0, r);
   for (int p = 0; p < 3; p++) begin
      send_packet(3, 1'b0);
   end
   wait_cycles(4);
   check_word("flits out while blocked", got_q.size() - got_mark, 32'd0);
   axi_read(ADDR_DROPS, d, r);
   check_word("drops", d, d0 + 32'd9);
   axi_write(ADDR_THRESHOLD, 32'd700, r);
   check_resp("bresp", r, RESP_OKAY);
   axi_write(ADDR_STATUS, 32'h2, r);
   check_resp("bresp", r, RESP_OKAY);
   check_word("port_blocked", 32'(port_blocked), 32'd0);
   start_window();
   send_packet(3, 1'b0);
   send_packet(3, 1'b0);
   drain_and_compare();
endtask

`endif

// ==== sim/tb_router_guard.sv ====
`timescale 1ns/1ps

module tb_router_guard
   import noc_pkg::*;
();

   localparam int TIMEOUT = 400;

   logic                   clk;
   logic                   reset;
   flit_t                  in_flit;
   logic                   in_ready;
   flit_t                  out_flit;
   logic                   out_ready;
   logic                   priv_inc;
   logic                   priv_dec;
   logic                   dos_detected;
   logic                   port_blocked;
   logic [AXIL_ADDR_W-1:0] awaddr;
   logic                   awvalid;
   logic                   awready;
   logic [AXIL_DATA_W-1:0] wdata;
   logic [AXIL_STRB_W-1:0] wstrb;
   logic                   wvalid;
   logic                   wready;
   logic [1:0]             bresp;
   logic                   bvalid;
   logic                   bready;
   logic [AXIL_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [AXIL_DATA_W-1:0] rdata;
   logic [1:0]             rresp;
   logic                   rvalid;
   logic                   rready;

   // flits sent by the tests and flits seen leaving the DUT
   flit_t       sent_q[$];
   flit_t       got_q[$];
   int          got_mark = 0;
   logic [31:0] lfsr_state = 32'h29f0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          throttle_errors = 0;
   logic        prev_open = 1'b0;

   tb_clock clock0 (.clk, .reset);

   router_guard dut0 (.clk, .reset, .in_flit, .in_ready, .out_flit, .out_ready,
                      .priv_inc, .priv_dec, .dos_detected, .port_blocked,
                      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
                      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
                      .rdata, .rresp, .rvalid, .rready);

   `include "tb_tasks.svh"

   // output capture and throttle watch at mid cycle
   always @(negedge clk) begin
      if (reset === 1'b0) begin
         if (out_flit.valid && out_ready) begin
            got_q.push_back(out_flit);
         end
         if (dos_detected && !port_blocked && in_ready && prev_open) begin
            throttle_errors++;
            $display("in_ready was high on two cycles in a row while throttled at %0d ns",
                     $time);
         end
         prev_open = dos_detected && !port_blocked && in_ready;
      end
   end

   initial begin
      int n;
      in_flit   = '0;
      out_ready = 1'b1;
      priv_inc  = 1'b0;
      priv_dec  = 1'b0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      n = 0;
      @(posedge clk);
      while (reset !== 1'b0 && n < 100) begin
         @(posedge clk);
         n++;
      end
      if (reset !== 1'b0) begin
         other_errors++;
         $display("reset was never released");
      end
      @(posedge clk);
      #1;
      test_reset_values();
      test_privilege();
      test_pass_through();
      test_detection();
      test_recovery();
      test_block();
      $display("errors: %0d value mismatches, %0d other failures",
               value_errors, other_errors + throttle_errors);
      if (value_errors == 0 && other_errors + throttle_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+sim
design/noc_pkg.sv
design/dos_monitor.sv
design/inject_gate.sv
design/guard_csr.sv
design/router_guard.sv
sim/tb_clock.sv
sim/tb_router_guard.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_router_guard
FILELIST  = sources.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
